// File: rtl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'hbfc00000

// primary opcodes
`define OP_SPECIAL  6'h00
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// funct field of SPECIAL
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`define ALU_OP_W    3
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_SLT     3'd4
`define ALU_LUI     3'd5

`endif

// File: rtl/mips_pkg.sv
`default_nettype none

`include "mips_settings.svh"

package mips_pkg;

    // one fetched word, read as R or I format
    typedef union packed {
        struct packed {
            logic [5:0]             opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [`REG_ADDR_W-1:0] rd;
            logic [4:0]             shamt;
            logic [5:0]             funct;
        } r;
        struct packed {
            logic [5:0]             opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [15:0]            imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`default_nettype none

`include "mips_settings.svh"

module fetch_unit (
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    // instruction bus, read only
    output logic                ibus_cyc_o,
    output logic                ibus_stb_o,
    output logic [`XLEN-1:0]    ibus_adr_o,
    input  wire  [`XLEN-1:0]    ibus_dat_i,
    input  wire                 ibus_ack_i,
    // decode side
    input  wire                 id_take_i,
    input  wire                 branch_taken_i,
    input  wire  [`XLEN-1:0]    branch_target_i,
    output logic                ifid_valid_o,
    output logic [`XLEN-1:0]    ifid_pc_o,
    output mips_pkg::instr_t    ifid_instr_o
);

    logic [`XLEN-1:0] pc_q;
    logic             cyc_q;
    logic             redir_q;      // target waits behind the delay slot
    logic [`XLEN-1:0] redir_pc_q;
    logic             redir_now;
    logic             fetch_done;

    assign redir_now  = id_take_i & branch_taken_i;
    assign fetch_done = cyc_q & ibus_ack_i;
    assign ibus_cyc_o = cyc_q;
    assign ibus_stb_o = cyc_q;
    assign ibus_adr_o = pc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q         <= `RESET_PC;
            cyc_q        <= 1'b0;
            redir_q      <= 1'b0;
            ifid_valid_o <= 1'b0;
        end else begin
            if (cyc_q)
                cyc_q <= ~ibus_ack_i;
            else
                cyc_q <= ~ifid_valid_o | id_take_i; // slot free by the time data lands
            if (redir_now)
                redir_q <= 1'b1;
            if (fetch_done) begin
                ifid_valid_o <= 1'b1;
                redir_q      <= 1'b0;
                if (redir_now)
                    pc_q <= branch_target_i;
                else if (redir_q)
                    pc_q <= redir_pc_q;
                else
                    pc_q <= pc_q + 'd4;
            end else if (id_take_i) begin
                ifid_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (redir_now)
            redir_pc_q <= branch_target_i;
        if (fetch_done) begin
            ifid_pc_o    <= pc_q;
            ifid_instr_o <= ibus_dat_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ibus_cyc_o |-> ibus_adr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/decode_unit.sv
`default_nettype none

`include "mips_settings.svh"

module decode_unit (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     ifid_valid_i,
    input  wire  [`XLEN-1:0]        ifid_pc_i,
    input  wire  mips_pkg::instr_t  ifid_instr_i,
    input  wire                     mem_stall_i,
    output logic                    id_take_o,
    output logic                    branch_taken_o,
    output logic [`XLEN-1:0]        branch_target_o,
    // bypass sources
    input  wire  [`XLEN-1:0]        ex_result_i,
    input  wire                     exmem_valid_i,
    input  wire                     exmem_rf_we_i,
    input  wire  [`REG_ADDR_W-1:0]  exmem_rd_i,
    input  wire                     exmem_load_i,
    input  wire  [`XLEN-1:0]        exmem_result_i,
    input  wire                     wb_rf_we_i,
    input  wire  [`REG_ADDR_W-1:0]  wb_rf_wnum_i,
    input  wire  [`XLEN-1:0]        wb_rf_wdata_i,
    // ID/EX
    output logic                    idex_valid_o,
    output logic [`XLEN-1:0]        idex_pc_o,
    output logic [`ALU_OP_W-1:0]    idex_alu_op_o,
    output logic [`XLEN-1:0]        idex_op_a_o,
    output logic [`XLEN-1:0]        idex_op_b_o,
    output logic                    idex_rf_we_o,
    output logic [`REG_ADDR_W-1:0]  idex_rd_o,
    output logic                    idex_load_o,
    output logic                    idex_store_o,
    output logic [`XLEN-1:0]        idex_store_data_o
);

    logic [`XLEN-1:0]       rf_q [1 << `REG_ADDR_W];
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`XLEN-1:0]       rs_val;
    logic [`XLEN-1:0]       rt_val;
    logic [`XLEN-1:0]       imm_sext;
    logic [`ALU_OP_W-1:0]   alu_op;
    logic [`XLEN-1:0]       op_b;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rf_we;
    logic                   load;
    logic                   store;
    logic                   uses_rt;
    logic                   is_beq;
    logic                   is_bne;
    logic                   load_hazard;

    // newest producer wins, rf read is write-through
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (idex_valid_o && idex_rf_we_o && idex_rd_o == idx)
            return ex_result_i;
        if (exmem_valid_i && exmem_rf_we_i && !exmem_load_i && exmem_rd_i == idx)
            return exmem_result_i;
        if (wb_rf_we_i && wb_rf_wnum_i == idx)
            return wb_rf_wdata_i;
        return rf_q[idx];
    endfunction

    assign rs       = ifid_instr_i.r.rs;
    assign rt       = ifid_instr_i.r.rt;
    assign imm_sext = {{(`XLEN-16){ifid_instr_i.i.imm[15]}}, ifid_instr_i.i.imm};

    always_comb begin
        rs_val = read_reg(rs);
        rt_val = read_reg(rt);
    end

    ////////////////////////////////////////
    // instruction decode
    always_comb begin
        alu_op  = `ALU_ADD;
        op_b    = imm_sext;
        rd      = ifid_instr_i.i.rt;
        rf_we   = 1'b1;
        load    = 1'b0;
        store   = 1'b0;
        uses_rt = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        case (ifid_instr_i.r.opcode)
            `OP_SPECIAL: begin
                op_b    = rt_val;
                rd      = ifid_instr_i.r.rd;
                uses_rt = 1'b1;
                case (ifid_instr_i.r.funct)
                    `FN_ADDU: alu_op = `ALU_ADD;
                    `FN_SUBU: alu_op = `ALU_SUB;
                    `FN_AND:  alu_op = `ALU_AND;
                    `FN_OR:   alu_op = `ALU_OR;
                    `FN_SLT:  alu_op = `ALU_SLT;
                    default:  rf_we  = 1'b0;    // sll nop and the rest
                endcase
            end
            `OP_ADDIU: alu_op = `ALU_ADD;
            `OP_ORI: begin
                alu_op = `ALU_OR;
                op_b   = {{(`XLEN-16){1'b0}}, ifid_instr_i.i.imm};
            end
            `OP_LUI:   alu_op = `ALU_LUI;
            `OP_LW:    load   = 1'b1;
            `OP_SW: begin
                rf_we   = 1'b0;
                store   = 1'b1;
                uses_rt = 1'b1;
            end
            `OP_BEQ: begin
                rf_we   = 1'b0;
                uses_rt = 1'b1;
                is_beq  = 1'b1;
            end
            `OP_BNE: begin
                rf_we   = 1'b0;
                uses_rt = 1'b1;
                is_bne  = 1'b1;
            end
            default:   rf_we  = 1'b0;
        endcase
    end

    // load result not ready until WB
    assign load_hazard =
        (idex_valid_o && idex_load_o && idex_rd_o != '0 &&
         (idex_rd_o == rs || (uses_rt && idex_rd_o == rt))) ||
        (exmem_valid_i && exmem_load_i && exmem_rd_i != '0 &&
         (exmem_rd_i == rs || (uses_rt && exmem_rd_i == rt)));

    assign id_take_o       = ifid_valid_i & ~mem_stall_i & ~load_hazard;
    assign branch_taken_o  = (is_beq & (rs_val == rt_val)) | (is_bne & (rs_val != rt_val));
    assign branch_target_o = ifid_pc_i + 'd4 + {imm_sext[`XLEN-3:0], 2'b00};

    ////////////////////////////////////////
    // register file and ID/EX
    always_ff @(posedge clk_i) begin
        if (wb_rf_we_i)
            rf_q[wb_rf_wnum_i] <= wb_rf_wdata_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idex_valid_o <= 1'b0;
            idex_rf_we_o <= 1'b0;
            idex_load_o  <= 1'b0;
            idex_store_o <= 1'b0;
        end else if (!mem_stall_i) begin
            idex_valid_o <= id_take_o;          // bubble on hazard
            idex_rf_we_o <= id_take_o & rf_we;
            idex_load_o  <= id_take_o & load;
            idex_store_o <= id_take_o & store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!mem_stall_i) begin
            idex_pc_o         <= ifid_pc_i;
            idex_alu_op_o     <= alu_op;
            idex_op_a_o       <= rs_val;
            idex_op_b_o       <= op_b;
            idex_rd_o         <= rd;
            idex_store_data_o <= rt_val;
        end
    end

    // r0 filtering is up to the memory stage
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_rf_we_i |-> wb_rf_wnum_i != '0);

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`default_nettype none

`include "mips_settings.svh"

module execute_unit (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     mem_stall_i,
    input  wire                     idex_valid_i,
    input  wire  [`XLEN-1:0]        idex_pc_i,
    input  wire  [`ALU_OP_W-1:0]    idex_alu_op_i,
    input  wire  [`XLEN-1:0]        idex_op_a_i,
    input  wire  [`XLEN-1:0]        idex_op_b_i,
    input  wire                     idex_rf_we_i,
    input  wire  [`REG_ADDR_W-1:0]  idex_rd_i,
    input  wire                     idex_load_i,
    input  wire                     idex_store_i,
    input  wire  [`XLEN-1:0]        idex_store_data_i,
    output logic [`XLEN-1:0]        ex_result_o,
    output logic                    exmem_valid_o,
    output logic [`XLEN-1:0]        exmem_pc_o,
    output logic                    exmem_rf_we_o,
    output logic [`REG_ADDR_W-1:0]  exmem_rd_o,
    output logic                    exmem_load_o,
    output logic                    exmem_store_o,
    output logic [`XLEN-1:0]        exmem_result_o,
    output logic [`XLEN-1:0]        exmem_store_data_o
);

    always_comb begin
        case (idex_alu_op_i)
            `ALU_ADD: ex_result_o = idex_op_a_i + idex_op_b_i;  // also lw/sw address
            `ALU_SUB: ex_result_o = idex_op_a_i - idex_op_b_i;
            `ALU_AND: ex_result_o = idex_op_a_i & idex_op_b_i;
            `ALU_OR:  ex_result_o = idex_op_a_i | idex_op_b_i;
            `ALU_SLT: ex_result_o = {{(`XLEN-1){1'b0}},
                                     $signed(idex_op_a_i) < $signed(idex_op_b_i)};
            `ALU_LUI: ex_result_o = {idex_op_b_i[15:0], 16'h0000};
            default:  ex_result_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exmem_valid_o <= 1'b0;
            exmem_rf_we_o <= 1'b0;
            exmem_load_o  <= 1'b0;
            exmem_store_o <= 1'b0;
        end else if (!mem_stall_i) begin
            exmem_valid_o <= idex_valid_i;
            exmem_rf_we_o <= idex_rf_we_i;
            exmem_load_o  <= idex_load_i;
            exmem_store_o <= idex_store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!mem_stall_i) begin
            exmem_pc_o         <= idex_pc_i;
            exmem_rd_o         <= idex_rd_i;
            exmem_result_o     <= ex_result_o;
            exmem_store_data_o <= idex_store_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/memory_unit.sv
`default_nettype none

`include "mips_settings.svh"

module memory_unit (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     exmem_valid_i,
    input  wire  [`XLEN-1:0]        exmem_pc_i,
    input  wire                     exmem_rf_we_i,
    input  wire  [`REG_ADDR_W-1:0]  exmem_rd_i,
    input  wire                     exmem_load_i,
    input  wire                     exmem_store_i,
    input  wire  [`XLEN-1:0]        exmem_result_i,
    input  wire  [`XLEN-1:0]        exmem_store_data_i,
    // data bus
    output logic                    dbus_cyc_o,
    output logic                    dbus_stb_o,
    output logic                    dbus_we_o,
    output logic [`XLEN-1:0]        dbus_adr_o,
    output logic [`XLEN-1:0]        dbus_dat_o,
    input  wire  [`XLEN-1:0]        dbus_dat_i,
    input  wire                     dbus_ack_i,
    output logic                    mem_stall_o,
    // MEM/WB, also the trace port
    output logic                    wb_rf_we_o,
    output logic [`REG_ADDR_W-1:0]  wb_rf_wnum_o,
    output logic [`XLEN-1:0]        wb_rf_wdata_o,
    output logic [`XLEN-1:0]        wb_pc_o
);

    logic mem_op;
    logic done_q;   // bus cycle closed at the last edge
    logic acked;

    assign mem_op      = exmem_valid_i & (exmem_load_i | exmem_store_i);
    assign dbus_cyc_o  = mem_op & ~done_q;  // one idle cycle between back-to-back accesses
    assign dbus_stb_o  = dbus_cyc_o;
    assign dbus_we_o   = exmem_store_i;
    assign dbus_adr_o  = exmem_result_i;
    assign dbus_dat_o  = exmem_store_data_i;
    assign acked       = dbus_cyc_o & dbus_ack_i;
    assign mem_stall_o = mem_op & ~acked;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q     <= 1'b0;
            wb_rf_we_o <= 1'b0;
        end else begin
            done_q     <= acked;
            wb_rf_we_o <= ~mem_stall_o & exmem_valid_i & exmem_rf_we_i & (exmem_rd_i != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rf_wnum_o  <= exmem_rd_i;
        wb_pc_o       <= exmem_pc_i;
        wb_rf_wdata_o <= exmem_load_i ? dbus_dat_i : exmem_result_i;
    end

    ////////////////////////////////////////
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dbus_cyc_o |-> dbus_adr_o[1:0] == 2'b00);

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dbus_cyc_o && !dbus_ack_i |=> dbus_cyc_o && $stable(dbus_we_o));

endmodule

`default_nettype wire

// File: rtl/mips_core.sv
`default_nettype none

`include "mips_settings.svh"

module mips_core (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    output logic                    ibus_cyc_o,
    output logic                    ibus_stb_o,
    output logic [`XLEN-1:0]        ibus_adr_o,
    input  wire  [`XLEN-1:0]        ibus_dat_i,
    input  wire                     ibus_ack_i,
    output logic                    dbus_cyc_o,
    output logic                    dbus_stb_o,
    output logic                    dbus_we_o,
    output logic [`XLEN-1:0]        dbus_adr_o,
    output logic [`XLEN-1:0]        dbus_dat_o,
    input  wire  [`XLEN-1:0]        dbus_dat_i,
    input  wire                     dbus_ack_i,
    // write-back trace
    output logic [`XLEN-1:0]        wb_pc_o,
    output logic                    wb_rf_we_o,
    output logic [`REG_ADDR_W-1:0]  wb_rf_wnum_o,
    output logic [`XLEN-1:0]        wb_rf_wdata_o
);

    import mips_pkg::*;

    logic                   ifid_valid;
    logic [`XLEN-1:0]       ifid_pc;
    instr_t                 ifid_instr;
    logic                   id_take;
    logic                   branch_taken;
    logic [`XLEN-1:0]       branch_target;
    logic                   mem_stall;
    logic [`XLEN-1:0]       ex_result;

    logic                   idex_valid;
    logic [`XLEN-1:0]       idex_pc;
    logic [`ALU_OP_W-1:0]   idex_alu_op;
    logic [`XLEN-1:0]       idex_op_a;
    logic [`XLEN-1:0]       idex_op_b;
    logic                   idex_rf_we;
    logic [`REG_ADDR_W-1:0] idex_rd;
    logic                   idex_load;
    logic                   idex_store;
    logic [`XLEN-1:0]       idex_store_data;

    logic                   exmem_valid;
    logic [`XLEN-1:0]       exmem_pc;
    logic                   exmem_rf_we;
    logic [`REG_ADDR_W-1:0] exmem_rd;
    logic                   exmem_load;
    logic                   exmem_store;
    logic [`XLEN-1:0]       exmem_result;
    logic [`XLEN-1:0]       exmem_store_data;

    ////////////////////////////////////////
    fetch_unit u_fetch (
        .clk_i, .arst_n_i,
        .ibus_cyc_o, .ibus_stb_o, .ibus_adr_o, .ibus_dat_i, .ibus_ack_i,
        .id_take_i       (id_take),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .ifid_valid_o    (ifid_valid),
        .ifid_pc_o       (ifid_pc),
        .ifid_instr_o    (ifid_instr)
    );

    decode_unit u_decode (
        .clk_i, .arst_n_i,
        .ifid_valid_i     (ifid_valid),
        .ifid_pc_i        (ifid_pc),
        .ifid_instr_i     (ifid_instr),
        .mem_stall_i      (mem_stall),
        .id_take_o        (id_take),
        .branch_taken_o   (branch_taken),
        .branch_target_o  (branch_target),
        .ex_result_i      (ex_result),
        .exmem_valid_i    (exmem_valid),
        .exmem_rf_we_i    (exmem_rf_we),
        .exmem_rd_i       (exmem_rd),
        .exmem_load_i     (exmem_load),
        .exmem_result_i   (exmem_result),
        .wb_rf_we_i       (wb_rf_we_o),
        .wb_rf_wnum_i     (wb_rf_wnum_o),
        .wb_rf_wdata_i    (wb_rf_wdata_o),
        .idex_valid_o     (idex_valid),
        .idex_pc_o        (idex_pc),
        .idex_alu_op_o    (idex_alu_op),
        .idex_op_a_o      (idex_op_a),
        .idex_op_b_o      (idex_op_b),
        .idex_rf_we_o     (idex_rf_we),
        .idex_rd_o        (idex_rd),
        .idex_load_o      (idex_load),
        .idex_store_o     (idex_store),
        .idex_store_data_o(idex_store_data)
    );

    execute_unit u_execute (
        .clk_i, .arst_n_i,
        .mem_stall_i       (mem_stall),
        .idex_valid_i      (idex_valid),
        .idex_pc_i         (idex_pc),
        .idex_alu_op_i     (idex_alu_op),
        .idex_op_a_i       (idex_op_a),
        .idex_op_b_i       (idex_op_b),
        .idex_rf_we_i      (idex_rf_we),
        .idex_rd_i         (idex_rd),
        .idex_load_i       (idex_load),
        .idex_store_i      (idex_store),
        .idex_store_data_i (idex_store_data),
        .ex_result_o       (ex_result),
        .exmem_valid_o     (exmem_valid),
        .exmem_pc_o        (exmem_pc),
        .exmem_rf_we_o     (exmem_rf_we),
        .exmem_rd_o        (exmem_rd),
        .exmem_load_o      (exmem_load),
        .exmem_store_o     (exmem_store),
        .exmem_result_o    (exmem_result),
        .exmem_store_data_o(exmem_store_data)
    );

    memory_unit u_memory (
        .clk_i, .arst_n_i,
        .exmem_valid_i     (exmem_valid),
        .exmem_pc_i        (exmem_pc),
        .exmem_rf_we_i     (exmem_rf_we),
        .exmem_rd_i        (exmem_rd),
        .exmem_load_i      (exmem_load),
        .exmem_store_i     (exmem_store),
        .exmem_result_i    (exmem_result),
        .exmem_store_data_i(exmem_store_data),
        .dbus_cyc_o, .dbus_stb_o, .dbus_we_o, .dbus_adr_o, .dbus_dat_o,
        .dbus_dat_i, .dbus_ack_i,
        .mem_stall_o       (mem_stall),
        .wb_rf_we_o, .wb_rf_wnum_o, .wb_rf_wdata_o, .wb_pc_o
    );

endmodule

`default_nettype wire

// File: sim/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program image, each writer followed by its expected write-back
task automatic fill_tables();
    // alu and immediates, dependent chain
    emit(itype(OPC_ADDIU, 1, 0, 16'h0005));
    expect_wb(1, 32'h0000_0005, "addiu r1");
    emit(itype(OPC_ADDIU, 2, 0, 16'hfffd));
    expect_wb(2, 32'hffff_fffd, "addiu r2 negative");
    emit(rtype(FUNCT_ADDU, 3, 1, 2));
    expect_wb(3, 32'h0000_0002, "addu fwd ex and mem");
    emit(rtype(FUNCT_SUBU, 4, 3, 1));
    expect_wb(4, 32'hffff_fffd, "subu fwd ex and wb");
    emit(rtype(FUNCT_SLT, 5, 2, 1));
    expect_wb(5, 32'h0000_0001, "slt neg lt pos");
    emit(rtype(FUNCT_SLT, 6, 1, 2));
    expect_wb(6, 32'h0000_0000, "slt pos lt neg");
    emit(itype(OPC_LUI, 7, 0, 16'h1234));
    expect_wb(7, 32'h1234_0000, "lui");
    emit(itype(OPC_ORI, 7, 7, 16'h5678));
    expect_wb(7, 32'h1234_5678, "ori after lui");
    emit(itype(OPC_ADDIU, 9, 0, 16'h0ff0));
    expect_wb(9, 32'h0000_0ff0, "addiu mask");
    emit(rtype(FUNCT_AND, 8, 7, 9));
    expect_wb(8, 32'h0000_0670, "and");
    emit(rtype(FUNCT_OR, 10, 8, 1));
    expect_wb(10, 32'h0000_0675, "or");
    emit(itype(OPC_ORI, 11, 0, 16'h8000));
    expect_wb(11, 32'h0000_8000, "ori zero extend");

    // r0 stays zero
    emit(itype(OPC_ADDIU, 0, 0, 16'h0007));
    emit(rtype(FUNCT_ADDU, 12, 0, 0));
    expect_wb(12, 32'h0000_0000, "addu reads r0");

    // stores, then loads with load-use
    emit(itype(OPC_ADDIU, 13, 0, 16'h0040));
    expect_wb(13, 32'h0000_0040, "addiu base");
    emit(itype(OPC_SW, 7, 13, 16'h0008));
    expect_store(32'h0000_0048, 32'h1234_5678, "sw r7 plus 8");
    emit(itype(OPC_SW, 10, 13, 16'hfffc));
    expect_store(32'h0000_003c, 32'h0000_0675, "sw r10 minus 4");
    emit(itype(OPC_LW, 14, 13, 16'h0008));
    expect_wb(14, 32'h1234_5678, "lw r14 plus 8");
    emit(rtype(FUNCT_ADDU, 15, 14, 1));
    expect_wb(15, 32'h1234_567d, "addu load-use");
    emit(itype(OPC_LW, 16, 13, 16'hfffc));
    expect_wb(16, 32'h0000_0675, "lw r16 minus 4");
    emit(itype(OPC_ADDIU, 18, 0, 16'h0001));
    expect_wb(18, 32'h0000_0001, "addiu between");
    emit(rtype(FUNCT_ADDU, 17, 16, 18));
    expect_wb(17, 32'h0000_0676, "addu load in mem");
    emit(itype(OPC_SW, 17, 13, 16'h0000));
    expect_store(32'h0000_0040, 32'h0000_0676, "sw fwd data");

    // branches and delay slots
    emit(itype(OPC_BEQ, 1, 1, 16'h0002));       // taken
    emit(itype(OPC_ADDIU, 19, 0, 16'h0011));
    expect_wb(19, 32'h0000_0011, "beq delay slot");
    emit(itype(OPC_ADDIU, 20, 0, 16'h0022));    // skipped
    emit(itype(OPC_BNE, 2, 1, 16'h0002));       // taken
    emit(itype(OPC_ADDIU, 21, 0, 16'h0033));
    expect_wb(21, 32'h0000_0033, "bne delay slot");
    emit(itype(OPC_ADDIU, 20, 0, 16'h0044));    // skipped
    emit(itype(OPC_BNE, 1, 1, 16'h0002));       // not taken
    emit(itype(OPC_ADDIU, 22, 0, 16'h0055));
    expect_wb(22, 32'h0000_0055, "bne not taken delay slot");
    emit(itype(OPC_ADDIU, 23, 0, 16'h0066));
    expect_wb(23, 32'h0000_0066, "fall through");
    emit(rtype(FUNCT_ADDU, 24, 21, 22));
    expect_wb(24, 32'h0000_0088, "addu after branches");

    // parking loop, nop in the slot
    emit(itype(OPC_BEQ, 0, 0, 16'hffff));
    emit(32'h0000_0000);
endtask

`endif

// File: sim/tb_mips_core.sv
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] BOOT_PC         = 32'hbfc00000;
    localparam int          MAX_WAIT        = 3;
    localparam int          CYCLES_PER_WORD = 30;
    localparam int          DRAIN_CYCLES    = 20;
    localparam int          RAM_WORDS       = 64;

    // MIPS32 encodings
    localparam logic [5:0] OPC_BEQ    = 6'h04;
    localparam logic [5:0] OPC_BNE    = 6'h05;
    localparam logic [5:0] OPC_ADDIU  = 6'h09;
    localparam logic [5:0] OPC_ORI    = 6'h0d;
    localparam logic [5:0] OPC_LUI    = 6'h0f;
    localparam logic [5:0] OPC_LW     = 6'h23;
    localparam logic [5:0] OPC_SW     = 6'h2b;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic        ibus_cyc_o;
    logic        ibus_stb_o;
    logic [31:0] ibus_adr_o;
    logic [31:0] ibus_dat_i;
    logic        ibus_ack_i;
    logic        dbus_cyc_o;
    logic        dbus_stb_o;
    logic        dbus_we_o;
    logic [31:0] dbus_adr_o;
    logic [31:0] dbus_dat_o;
    logic [31:0] dbus_dat_i;
    logic        dbus_ack_i;
    logic [31:0] wb_pc_o;
    logic        wb_rf_we_o;
    logic [4:0]  wb_rf_wnum_o;
    logic [31:0] wb_rf_wdata_o;

    logic [31:0] prog       [$];
    logic [31:0] trace_pc   [$];
    logic [4:0]  trace_rd   [$];
    logic [31:0] trace_data [$];
    string       trace_name [$];
    logic [31:0] store_adr  [$];
    logic [31:0] store_data [$];
    string       store_name [$];
    logic [31:0] ram        [RAM_WORDS];

    logic [31:0] rng_state = 32'hbc34;
    logic        ibus_busy = 1'b0;
    logic        dbus_busy = 1'b0;
    int          ibus_wait;
    int          dbus_wait;
    logic [31:0] rom_offset;
    int          store_pos = 0;
    int          cycle_cnt = 0;
    int          timeout_cycles;

    mips_core DUT (.*);

    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////
    // helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // pc is that of the word emitted last
    task automatic expect_wb(input logic [4:0] rd, input logic [31:0] data, input string name);
        trace_pc.push_back(BOOT_PC + 32'(4 * (prog.size() - 1)));
        trace_rd.push_back(rd);
        trace_data.push_back(data);
        trace_name.push_back(name);
    endtask

    task automatic expect_store(input logic [31:0] adr, input logic [31:0] data,
                                input string name);
        store_adr.push_back(adr);
        store_data.push_back(data);
        store_name.push_back(name);
    endtask

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", name, field, expected, actual);
            end_with_failure();
        end
    endtask

    `include "tb_program.svh"

    ////////////////////////////////////////
    // bus slaves with random wait states
    always @(negedge clk_i) begin
        if (ibus_ack_i) begin
            ibus_ack_i = 1'b0;
            ibus_busy  = 1'b0;
        end else if (arst_n_i && ibus_cyc_o && ibus_stb_o) begin
            if (!ibus_busy) begin
                ibus_busy = 1'b1;
                rng_state = xorshift32(rng_state);
                ibus_wait = int'(rng_state % (MAX_WAIT + 1));
            end
            if (ibus_wait == 0) begin
                rom_offset = ibus_adr_o - BOOT_PC;
                assert (rom_offset < 32'(4 * prog.size())) else begin
                    $display("instruction fetch outside the program at %h", ibus_adr_o);
                    end_with_failure();
                end
                ibus_dat_i = prog[rom_offset[31:2]];
                ibus_ack_i = 1'b1;
            end else begin
                ibus_wait--;
            end
        end

        if (dbus_ack_i) begin
            dbus_ack_i = 1'b0;
            dbus_busy  = 1'b0;
        end else if (arst_n_i && dbus_cyc_o && dbus_stb_o) begin
            if (!dbus_busy) begin
                dbus_busy = 1'b1;
                rng_state = xorshift32(rng_state);
                dbus_wait = int'(rng_state % (MAX_WAIT + 1));
            end
            if (dbus_wait == 0) begin
                assert (dbus_adr_o < 32'(4 * RAM_WORDS)) else begin
                    $display("data access outside the RAM at %h", dbus_adr_o);
                    end_with_failure();
                end
                if (dbus_we_o) begin
                    assert (store_pos < store_adr.size()) else begin
                        $display("unexpected data-bus write to %h", dbus_adr_o);
                        end_with_failure();
                    end
                    check_value(store_name[store_pos], "address", store_adr[store_pos],
                                dbus_adr_o);
                    check_value(store_name[store_pos], "data", store_data[store_pos],
                                dbus_dat_o);
                    ram[dbus_adr_o[7:2]] = dbus_dat_o;
                    store_pos++;
                end else begin
                    dbus_dat_i = ram[dbus_adr_o[7:2]];
                end
                dbus_ack_i = 1'b1;
            end else begin
                dbus_wait--;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout after %0d cycles, the program did not finish", cycle_cnt);
            end_with_failure();
        end
    end

    ////////////////////////////////////////
    // reset, trace checking loop, end of run
    initial begin
        fill_tables();
        timeout_cycles = CYCLES_PER_WORD * prog.size();
        for (int i = 0; i < RAM_WORDS; i++)
            ram[i] = 32'h0;
        arst_n_i   = 1'b0;
        ibus_dat_i = 32'h0;
        ibus_ack_i = 1'b0;
        dbus_dat_i = 32'h0;
        dbus_ack_i = 1'b0;
        repeat (2) @(negedge clk_i);
        arst_n_i = 1'b1;

        for (int i = 0; i < trace_pc.size(); i++) begin
            @(negedge clk_i);
            while (!wb_rf_we_o)
                @(negedge clk_i);
            check_value(trace_name[i], "pc", trace_pc[i], wb_pc_o);
            check_value(trace_name[i], "register", 32'(trace_rd[i]), 32'(wb_rf_wnum_o));
            check_value(trace_name[i], "data", trace_data[i], wb_rf_wdata_o);
        end
        while (store_pos < store_adr.size())
            @(negedge clk_i);

        // parked in the self loop, nothing more may retire
        repeat (DRAIN_CYCLES) begin
            @(negedge clk_i);
            assert (!wb_rf_we_o) else begin
                $display("register write after the end of the program, r%0d at pc %h",
                         wb_rf_wnum_o, wb_pc_o);
                end_with_failure();
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
+incdir+sim
rtl/mips_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_unit.sv
rtl/mips_core.sv
sim/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/decode_unit.sv
      - rtl/execute_unit.sv
      - rtl/memory_unit.sv
      - rtl/mips_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mips_core.sv
